// File: acc_cfg_pkg.sv
package acc_cfg_pkg;

  // buffer geometry, one word per sample or result.
  localparam int BUF_DEPTH = 256;
  localparam int BUF_AW = 8;

  // host addresses arrive as byte offsets inside a window.
  localparam int ADDR_SHIFT = 2;
  localparam int HOST_AW = BUF_AW + ADDR_SHIFT;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // datapath widths.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int SAMPLE_W = 16;
  localparam int ACC_W = 32;

  // input buffer word, also used for the kernel taps.
  typedef logic signed [SAMPLE_W-1:0] sample_t;

  // output buffer word, the accumulator wraps at this width.
  typedef logic signed [ACC_W-1:0] acc_t;

endpackage

// File: apb_map_pkg.sv
package apb_map_pkg;

  localparam int APB_AW = 12;
  localparam int APB_DW = 32;

  // register offsets.
  localparam logic [APB_AW-1:0] REG_CTRL = 12'h000;
  localparam logic [APB_AW-1:0] REG_STATUS = 12'h004;
  localparam logic [APB_AW-1:0] REG_LEN = 12'h008;
  localparam logic [APB_AW-1:0] REG_K0 = 12'h00C;
  localparam logic [APB_AW-1:0] REG_K1 = 12'h010;
  localparam logic [APB_AW-1:0] REG_K2 = 12'h014;

  // buffer windows, 1 KB each, selected by the bits above WIN_LSB.
  localparam logic [APB_AW-1:0] IN_WIN_BASE = 12'h400;
  localparam logic [APB_AW-1:0] OUT_WIN_BASE = 12'h800;
  localparam int WIN_LSB = 10;

  localparam int CTRL_START_BIT = 0;
  localparam int STATUS_BUSY_BIT = 0;
  localparam int STATUS_DONE_BIT = 1;

endpackage

// File: apb_regs.sv
`timescale 1ns/10ps

module apb_regs (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            psel_i,
  input  logic                            penable_i,
  input  logic                            pwrite_i,
  input  logic [apb_map_pkg::APB_AW-1:0]  paddr_i,
  input  logic [apb_map_pkg::APB_DW-1:0]  pwdata_i,
  output logic [apb_map_pkg::APB_DW-1:0]  prdata_o,
  output logic                            pready_o,
  output logic                            pslverr_o,
  output logic                            start_o,
  output logic [acc_cfg_pkg::BUF_AW-1:0]  len_o,
  output acc_cfg_pkg::sample_t            k0_o,
  output acc_cfg_pkg::sample_t            k1_o,
  output acc_cfg_pkg::sample_t            k2_o,
  input  logic                            busy_i,
  input  logic                            done_i,
  output logic                            in_req_o,
  output logic                            in_we_o,
  output logic [acc_cfg_pkg::HOST_AW-1:0] in_addr_o,
  output acc_cfg_pkg::sample_t            in_wdata_o,
  input  acc_cfg_pkg::sample_t            in_rdata_i,
  output logic                            out_req_o,
  output logic                            out_we_o,
  output logic [acc_cfg_pkg::HOST_AW-1:0] out_addr_o,
  output acc_cfg_pkg::acc_t               out_wdata_o,
  input  acc_cfg_pkg::acc_t               out_rdata_i
);

  import acc_cfg_pkg::*;
  import apb_map_pkg::*;

  logic              setup;
  logic              access;
  logic              in_hit;
  logic              out_hit;
  logic              win_hit;
  logic              reg_hit;
  logic              buf_rd;
  logic              blocked;
  logic              blk_q;
  logic              rd_wait_q;
  logic              start_q;
  logic [BUF_AW-1:0] len_q;
  sample_t           k0_q;
  sample_t           k1_q;
  sample_t           k2_q;

  assign setup   = psel_i & ~penable_i;
  assign access  = psel_i & penable_i;
  assign in_hit  = paddr_i[APB_AW-1:WIN_LSB] == IN_WIN_BASE[APB_AW-1:WIN_LSB];
  assign out_hit = paddr_i[APB_AW-1:WIN_LSB] == OUT_WIN_BASE[APB_AW-1:WIN_LSB];
  assign win_hit = in_hit | out_hit;
  assign buf_rd  = win_hit & ~pwrite_i;

  always_comb begin
    case (paddr_i)
      REG_CTRL, REG_STATUS, REG_LEN, REG_K0, REG_K1, REG_K2: reg_hit = 1'b1;
      default: reg_hit = 1'b0;
    endcase
  end

  // busy is sampled in setup and held for the rest of the transfer.
  // a pending start counts as busy.
  assign blocked = setup ? (busy_i | start_q) : blk_q;

  assign pready_o  = access & (~buf_rd | rd_wait_q);
  assign pslverr_o = pready_o & ((~reg_hit & ~win_hit) | (win_hit & blocked));

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      blk_q     <= 1'b0;
      rd_wait_q <= 1'b0;
      start_q   <= 1'b0;
    end else begin
      if (setup) begin
        blk_q <= busy_i | start_q;
      end
      rd_wait_q <= access & buf_rd & ~rd_wait_q;
      start_q   <= access & pwrite_i & (paddr_i == REG_CTRL) &
                   pwdata_i[CTRL_START_BIT] & ~busy_i;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // configuration registers.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      len_q <= '0;
      k0_q  <= '0;
      k1_q  <= '0;
      k2_q  <= '0;
    end else if (access && pwrite_i) begin
      case (paddr_i)
        REG_LEN: len_q <= pwdata_i[BUF_AW-1:0];
        REG_K0:  k0_q <= pwdata_i[SAMPLE_W-1:0];
        REG_K1:  k1_q <= pwdata_i[SAMPLE_W-1:0];
        REG_K2:  k2_q <= pwdata_i[SAMPLE_W-1:0];
        default: ;
      endcase
    end
  end

  always_comb begin
    prdata_o = '0;
    if (in_hit) begin
      if (!blocked) prdata_o = APB_DW'(in_rdata_i);
    end else if (out_hit) begin
      if (!blocked) prdata_o = out_rdata_i;
    end else begin
      case (paddr_i)
        REG_STATUS: begin
          prdata_o[STATUS_BUSY_BIT] = busy_i;
          prdata_o[STATUS_DONE_BIT] = done_i;
        end
        REG_LEN: prdata_o = APB_DW'(len_q);
        REG_K0:  prdata_o = APB_DW'(k0_q);
        REG_K1:  prdata_o = APB_DW'(k1_q);
        REG_K2:  prdata_o = APB_DW'(k2_q);
        default: ;
      endcase
    end
  end

  assign start_o = start_q;
  assign len_o   = len_q;
  assign k0_o    = k0_q;
  assign k1_o    = k1_q;
  assign k2_o    = k2_q;

  // window offset goes to the wrappers as a byte address.
  assign in_req_o    = psel_i & in_hit & ~blocked;
  assign in_we_o     = pwrite_i;
  assign in_addr_o   = paddr_i[HOST_AW-1:0];
  assign in_wdata_o  = pwdata_i[SAMPLE_W-1:0];
  assign out_req_o   = psel_i & out_hit & ~blocked;
  assign out_we_o    = pwrite_i;
  assign out_addr_o  = paddr_i[HOST_AW-1:0];
  assign out_wdata_o = pwdata_i;

endmodule

// File: buf_sram.sv
`timescale 1ns/10ps

module buf_sram #(
  parameter type word_t = acc_cfg_pkg::sample_t
) (
  input  logic                           clk,
  input  logic                           en_i,
  input  logic                           we_i,
  input  logic [acc_cfg_pkg::BUF_AW-1:0] addr_i,
  input  word_t                          wdata_i,
  output word_t                          rdata_o
);

  import acc_cfg_pkg::*;

  word_t mem [BUF_DEPTH];

  // one port, registered read; a write returns the old word.
  always_ff @(posedge clk) begin
    if (en_i) begin
      if (we_i) begin
        mem[addr_i] <= wdata_i;
      end
      rdata_o <= mem[addr_i];
    end
  end

endmodule

// File: buf_wrapper.sv
`timescale 1ns/10ps

module buf_wrapper #(
  parameter type word_t = acc_cfg_pkg::sample_t
) (
  input  logic                            clk,
  input  logic                            rst,
  // engine side.
  input  logic                            eng_busy_i,
  input  logic                            eng_en_i,
  input  logic                            eng_we_i,
  input  logic [acc_cfg_pkg::BUF_AW-1:0]  eng_addr_i,
  input  word_t                           eng_wdata_i,
  output word_t                           eng_rdata_o,
  // host side, byte addressed.
  input  logic                            host_req_i,
  input  logic                            host_we_i,
  input  logic [acc_cfg_pkg::HOST_AW-1:0] host_addr_i,
  input  word_t                           host_wdata_i,
  output word_t                           host_rdata_o
);

  import acc_cfg_pkg::*;

  typedef enum logic [1:0] {
    S_IDLE   = 2'd0,
    S_ENG    = 2'd1,
    S_HOST_R = 2'd2,
    S_HOST_W = 2'd3
  } own_state_t;

  own_state_t        state_q;
  own_state_t        state_d;
  logic              sram_en;
  logic              sram_we;
  logic [BUF_AW-1:0] sram_addr;
  logic [BUF_AW-1:0] host_word_addr;
  word_t             sram_wdata;
  word_t             sram_rdata;

  buf_sram #(.word_t(word_t)) i_sram (
    .clk    (clk),
    .en_i   (sram_en),
    .we_i   (sram_we),
    .addr_i (sram_addr),
    .wdata_i(sram_wdata),
    .rdata_o(sram_rdata)
  );

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state_q <= S_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      S_IDLE: begin
        if (eng_busy_i) begin
          state_d = S_ENG;
        end else if (host_req_i) begin
          state_d = host_we_i ? S_HOST_W : S_HOST_R;
        end
      end
      S_ENG: if (!eng_busy_i) state_d = S_IDLE;
      // back to back host transfers may switch direction.
      default: begin
        if (!host_req_i) begin
          state_d = S_IDLE;
        end else begin
          state_d = host_we_i ? S_HOST_W : S_HOST_R;
        end
      end
    endcase
  end

  assign host_word_addr = host_addr_i[HOST_AW-1:ADDR_SHIFT];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // sram steering.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    sram_en    = 1'b0;
    sram_we    = 1'b0;
    sram_addr  = '0;
    sram_wdata = '0;
    case (state_q)
      S_ENG: begin
        sram_en    = eng_en_i;
        sram_we    = eng_we_i;
        sram_addr  = eng_addr_i;
        sram_wdata = eng_wdata_i;
      end
      S_HOST_R: begin
        sram_en   = host_req_i;
        sram_addr = host_word_addr;
      end
      S_HOST_W: begin
        sram_en    = host_req_i;
        sram_we    = host_req_i & host_we_i;
        sram_addr  = host_word_addr;
        sram_wdata = host_wdata_i;
      end
      default: begin
        // first engine read or an early host read may start here.
        if (eng_busy_i) begin
          sram_en    = eng_en_i;
          sram_we    = eng_we_i;
          sram_addr  = eng_addr_i;
          sram_wdata = eng_wdata_i;
        end else if (host_req_i && !host_we_i) begin
          sram_en   = 1'b1;
          sram_addr = host_word_addr;
        end
      end
    endcase
  end

  assign eng_rdata_o  = (state_q == S_ENG) ? sram_rdata : '0;
  assign host_rdata_o = (state_q == S_HOST_R) ? sram_rdata : '0;

endmodule

// File: build.f
acc_cfg_pkg.sv
apb_map_pkg.sv
buf_sram.sv
buf_wrapper.sv
conv_engine.sv
apb_regs.sv
conv_acc_top.sv
conv_acc_checker.sv
tb_conv_acc.sv

// File: conv_acc_checker.sv
`timescale 1ns/10ps

module conv_acc_checker (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           psel_i,
  input  logic                           penable_i,
  input  logic                           pwrite_i,
  input  logic [apb_map_pkg::APB_AW-1:0] paddr_i,
  input  logic [apb_map_pkg::APB_DW-1:0] pwdata_i,
  input  logic [apb_map_pkg::APB_DW-1:0] prdata_i,
  input  logic                           pready_i,
  input  logic                           pslverr_i,
  // 0 checks pslverr only, 1 compares with the record, 2 with the model.
  input  logic [1:0]                     cmp_mode_i,
  input  logic [apb_map_pkg::APB_DW-1:0] exp_data_i,
  input  logic                           exp_err_i,
  output int                             errors_o
);

  import acc_cfg_pkg::*;
  import apb_map_pkg::*;

  sample_t           in_mem [BUF_DEPTH];
  acc_t              out_mem [BUF_DEPTH];
  logic [BUF_AW-1:0] len_m;
  sample_t           k0_m;
  sample_t           k1_m;
  sample_t           k2_m;
  int                remain;
  int                wait_n;

  function automatic logic [31:0] model_read(input logic [APB_AW-1:0] a);
    case (a[11:10])
      2'd1: return 32'(in_mem[a[9:2]]);
      2'd2: return out_mem[a[9:2]];
      default: begin
        case (a)
          REG_LEN: return 32'(len_m);
          REG_K0:  return 32'(k0_m);
          REG_K1:  return 32'(k1_m);
          REG_K2:  return 32'(k2_m);
          default: return 32'h0;
        endcase
      end
    endcase
  endfunction

  // only a buffer window read waits one cycle for the sram.
  function automatic int wait_states(input logic we, input logic [APB_AW-1:0] a);
    if (!we && (a[11:10] == 2'd1 || a[11:10] == 2'd2)) return 1;
    return 0;
  endfunction

  // out[k] = k0*in[k] + k1*in[k+1] + k2*in[k+2] wraps at 32 bits.
  task automatic run_model();
    int acc;
    for (int k = 0; k < int'(len_m); k++) begin
      acc = int'(k0_m) * int'(in_mem[k]) + int'(k1_m) * int'(in_mem[(k + 1) & 255]) +
            int'(k2_m) * int'(in_mem[(k + 2) & 255]);
      out_mem[k] = acc;
    end
  endtask

  task automatic report(input string name, input logic [31:0] exp, input logic [31:0] act);
    $display("CHECK FAILED at %0t: %s expected %h got %h (paddr %h)",
             $time, name, exp, act, paddr_i);
    errors_o++;
  endtask

  always @(posedge clk or posedge rst) begin
    if (rst) begin
      len_m  <= '0;
      k0_m   <= '0;
      k1_m   <= '0;
      k2_m   <= '0;
      remain = 0;
      wait_n = 0;
    end else begin
      if (remain > 0) remain--;
      if (pready_i && !(psel_i && penable_i)) begin
        report("pready", 32'h0, 32'(pready_i));
      end
      if (psel_i && penable_i && !pready_i) wait_n++;
      if (psel_i && penable_i && pready_i) begin
        if (wait_n != wait_states(pwrite_i, paddr_i)) begin
          report("pready wait cycles", 32'(wait_states(pwrite_i, paddr_i)), 32'(wait_n));
        end
        wait_n = 0;
        if (cmp_mode_i == 2'd1) begin
          if (pslverr_i !== exp_err_i) report("pslverr", 32'(exp_err_i), 32'(pslverr_i));
          if (!pwrite_i && prdata_i !== exp_data_i) report("prdata", exp_data_i, prdata_i);
        end else begin
          if (pslverr_i !== 1'b0) report("pslverr", 32'h0, 32'(pslverr_i));
          if (cmp_mode_i == 2'd2 && !pwrite_i && prdata_i !== model_read(paddr_i)) begin
            report("prdata", model_read(paddr_i), prdata_i);
          end
        end
        if (pwrite_i && cmp_mode_i != 2'd0 && !(cmp_mode_i == 2'd1 && exp_err_i)) begin
          case (paddr_i[11:10])
            2'd1: in_mem[paddr_i[9:2]] = pwdata_i[15:0];
            2'd2: out_mem[paddr_i[9:2]] = pwdata_i;
            default: begin
              case (paddr_i)
                REG_LEN: len_m <= pwdata_i[BUF_AW-1:0];
                REG_K0:  k0_m <= pwdata_i[15:0];
                REG_K1:  k1_m <= pwdata_i[15:0];
                REG_K2:  k2_m <= pwdata_i[15:0];
                REG_CTRL: begin
                  // a start while the engine runs is dropped.
                  if (pwdata_i[CTRL_START_BIT] && remain == 0) begin
                    run_model();
                    remain = int'(len_m) + 5;
                  end
                end
                default: ;
              endcase
            end
          endcase
        end
      end
    end
  end

  initial errors_o = 0;

endmodule

// File: conv_acc_stim.txt
# op addr data err : w write, r read and compare data, m read against the model
# p polls STATUS until done; addr and data in hex, err 0 or 1
r 004 00000000 0
r 008 00000000 0
r 00C 00000000 0
r 010 00000000 0
r 014 00000000 0
r 01C 00000000 1
r 300 00000000 1
w 400 00007fff 0
w 404 00008000 0
w 408 00000001 0
w 40C 0000ffff 0
w 410 00000100 0
w 414 00001234 0
w 418 0000fff0 0
w 41C 00000005 0
r 400 00007fff 0
r 404 ffff8000 0
r 40C ffffffff 0
r 41C 00000005 0
w 818 deadbeef 0
w 81C 80000001 0
r 818 deadbeef 0
r 81C 80000001 0
w 008 00000006 0
w 00C 00000002 0
w 010 0000ffff 0
w 014 fffffffd 0
r 010 ffffffff 0
r 014 fffffffd 0
w 000 00000001 0
w 000 00000001 0
r 400 00000000 1
w 404 00000000 1
p 004 00000000 0
m 800 00000000 0
m 804 00000000 0
m 808 00000000 0
m 80C 00000000 0
m 810 00000000 0
m 814 00000000 0
m 818 00000000 0
m 81C 00000000 0
m 404 00000000 0
r 004 00000002 0

// File: conv_acc_top.sv
`timescale 1ns/10ps

module conv_acc_top (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           psel_i,
  input  logic                           penable_i,
  input  logic                           pwrite_i,
  input  logic [apb_map_pkg::APB_AW-1:0] paddr_i,
  input  logic [apb_map_pkg::APB_DW-1:0] pwdata_i,
  output logic [apb_map_pkg::APB_DW-1:0] prdata_o,
  output logic                           pready_o,
  output logic                           pslverr_o
);

  import acc_cfg_pkg::*;

  logic               start;
  logic               busy;
  logic               done;
  logic [BUF_AW-1:0]  len;
  sample_t            k0;
  sample_t            k1;
  sample_t            k2;
  logic               in_req;
  logic               in_we;
  logic [HOST_AW-1:0] in_addr;
  sample_t            in_wdata;
  sample_t            in_rdata;
  logic               out_req;
  logic               out_we;
  logic [HOST_AW-1:0] out_addr;
  acc_t               out_wdata;
  acc_t               out_rdata;
  logic               eng_in_en;
  logic [BUF_AW-1:0]  eng_in_addr;
  sample_t            eng_in_rdata;
  logic               eng_out_en;
  logic               eng_out_we;
  logic [BUF_AW-1:0]  eng_out_addr;
  acc_t               eng_out_wdata;

  apb_regs i_apb_regs (
    .clk        (clk),
    .rst        (rst),
    .psel_i     (psel_i),
    .penable_i  (penable_i),
    .pwrite_i   (pwrite_i),
    .paddr_i    (paddr_i),
    .pwdata_i   (pwdata_i),
    .prdata_o   (prdata_o),
    .pready_o   (pready_o),
    .pslverr_o  (pslverr_o),
    .start_o    (start),
    .len_o      (len),
    .k0_o       (k0),
    .k1_o       (k1),
    .k2_o       (k2),
    .busy_i     (busy),
    .done_i     (done),
    .in_req_o   (in_req),
    .in_we_o    (in_we),
    .in_addr_o  (in_addr),
    .in_wdata_o (in_wdata),
    .in_rdata_i (in_rdata),
    .out_req_o  (out_req),
    .out_we_o   (out_we),
    .out_addr_o (out_addr),
    .out_wdata_o(out_wdata),
    .out_rdata_i(out_rdata)
  );

  conv_engine i_conv_engine (
    .clk        (clk),
    .rst        (rst),
    .start_i    (start),
    .len_i      (len),
    .k0_i       (k0),
    .k1_i       (k1),
    .k2_i       (k2),
    .busy_o     (busy),
    .done_o     (done),
    .in_en_o    (eng_in_en),
    .in_addr_o  (eng_in_addr),
    .in_rdata_i (eng_in_rdata),
    .out_en_o   (eng_out_en),
    .out_we_o   (eng_out_we),
    .out_addr_o (eng_out_addr),
    .out_wdata_o(eng_out_wdata)
  );

  // the engine only reads the input buffer.
  buf_wrapper #(.word_t(sample_t)) i_in_buf (
    .clk         (clk),
    .rst         (rst),
    .eng_busy_i  (busy),
    .eng_en_i    (eng_in_en),
    .eng_we_i    (1'b0),
    .eng_addr_i  (eng_in_addr),
    .eng_wdata_i ('0),
    .eng_rdata_o (eng_in_rdata),
    .host_req_i  (in_req),
    .host_we_i   (in_we),
    .host_addr_i (in_addr),
    .host_wdata_i(in_wdata),
    .host_rdata_o(in_rdata)
  );

  buf_wrapper #(.word_t(acc_t)) i_out_buf (
    .clk         (clk),
    .rst         (rst),
    .eng_busy_i  (busy),
    .eng_en_i    (eng_out_en),
    .eng_we_i    (eng_out_we),
    .eng_addr_i  (eng_out_addr),
    .eng_wdata_i (eng_out_wdata),
    .eng_rdata_o (),
    .host_req_i  (out_req),
    .host_we_i   (out_we),
    .host_addr_i (out_addr),
    .host_wdata_i(out_wdata),
    .host_rdata_o(out_rdata)
  );

endmodule

// File: conv_engine.sv
`timescale 1ns/10ps

module conv_engine (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           start_i,
  input  logic [acc_cfg_pkg::BUF_AW-1:0] len_i,
  input  acc_cfg_pkg::sample_t           k0_i,
  input  acc_cfg_pkg::sample_t           k1_i,
  input  acc_cfg_pkg::sample_t           k2_i,
  output logic                           busy_o,
  output logic                           done_o,
  // input buffer, read only.
  output logic                           in_en_o,
  output logic [acc_cfg_pkg::BUF_AW-1:0] in_addr_o,
  input  acc_cfg_pkg::sample_t           in_rdata_i,
  // output buffer, write only.
  output logic                           out_en_o,
  output logic                           out_we_o,
  output logic [acc_cfg_pkg::BUF_AW-1:0] out_addr_o,
  output acc_cfg_pkg::acc_t              out_wdata_o
);

  import acc_cfg_pkg::*;

  localparam int CW = BUF_AW + 2;

  logic              busy_q;
  logic              done_q;
  logic              vld_q;
  logic [CW-1:0]     t_q;
  logic [CW-1:0]     rd_last;
  logic [CW-1:0]     run_last;
  logic [CW-1:0]     wr_idx;
  logic              wr_fire;
  logic [BUF_AW-1:0] len_q;
  sample_t           k0_q;
  sample_t           k1_q;
  sample_t           k2_q;
  sample_t           win0_q;
  sample_t           win1_q;
  acc_t              prod0;
  acc_t              prod1;
  acc_t              prod2;

  // reads 0..len+1, the run ends one cycle after the last read returns.
  assign rd_last  = CW'(len_q) + CW'(1);
  assign run_last = CW'(len_q) + CW'(2);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      busy_q <= 1'b0;
      done_q <= 1'b0;
      vld_q  <= 1'b0;
      t_q    <= '0;
    end else begin
      vld_q <= in_en_o;
      if (start_i) begin
        busy_q <= 1'b1;
        done_q <= 1'b0;
        t_q    <= '0;
      end else if (busy_q) begin
        t_q <= t_q + CW'(1);
        if (t_q == run_last) begin
          busy_q <= 1'b0;
          done_q <= 1'b1;
        end
      end
    end
  end

  // run parameters are frozen at start.
  always_ff @(posedge clk) begin
    if (start_i) begin
      len_q <= len_i;
      k0_q  <= k0_i;
      k1_q  <= k1_i;
      k2_q  <= k2_i;
    end
    if (vld_q) begin
      win1_q <= in_rdata_i;
      win0_q <= win1_q;
    end
  end

  assign in_en_o   = busy_q && (t_q <= rd_last);
  assign in_addr_o = t_q[BUF_AW-1:0];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // mac, newest sample taken straight from the sram.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign prod0 = acc_t'(k0_q) * acc_t'(win0_q);
  assign prod1 = acc_t'(k1_q) * acc_t'(win1_q);
  assign prod2 = acc_t'(k2_q) * acc_t'(in_rdata_i);

  assign wr_fire     = vld_q && (t_q >= CW'(3));
  assign wr_idx      = t_q - CW'(3);
  assign out_en_o    = wr_fire;
  assign out_we_o    = wr_fire;
  assign out_addr_o  = wr_idx[BUF_AW-1:0];
  assign out_wdata_o = prod0 + prod1 + prod2;

  assign busy_o = busy_q;
  assign done_o = done_q;

endmodule

// File: run_sim.sh
#!/bin/bash
# compile and run the convolution accelerator testbench with verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f build.f --top-module tb_conv_acc -o sim_tb
if [ $? -ne 0 ]; then
  echo "verilator compile failed"
  exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Checks failed" sim.log; then
  exit 1
fi
exit 0

// File: tb_conv_acc.sv
`timescale 1ns/10ps

module tb_conv_acc;

  import acc_cfg_pkg::*;
  import apb_map_pkg::*;

  logic              clk;
  logic              rst;
  logic              psel;
  logic              penable;
  logic              pwrite;
  logic [APB_AW-1:0] paddr;
  logic [APB_DW-1:0] pwdata;
  logic [APB_DW-1:0] prdata;
  logic              pready;
  logic              pslverr;
  logic [1:0]        cmp_mode;
  logic [APB_DW-1:0] exp_data;
  logic              exp_err;
  int                errors;
  int                tb_errors;
  int                limit;
  logic [31:0]       lfsr_q;
  string             rec_op [$];
  logic [31:0]       rec_addr [$];
  logic [31:0]       rec_data [$];
  int                rec_err [$];

  conv_acc_top i_conv_acc_top (
    .clk      (clk),
    .rst      (rst),
    .psel_i   (psel),
    .penable_i(penable),
    .pwrite_i (pwrite),
    .paddr_i  (paddr),
    .pwdata_i (pwdata),
    .prdata_o (prdata),
    .pready_o (pready),
    .pslverr_o(pslverr)
  );

  conv_acc_checker i_checker (
    .clk       (clk),
    .rst       (rst),
    .psel_i    (psel),
    .penable_i (penable),
    .pwrite_i  (pwrite),
    .paddr_i   (paddr),
    .pwdata_i  (pwdata),
    .prdata_i  (prdata),
    .pready_i  (pready),
    .pslverr_i (pslverr),
    .cmp_mode_i(cmp_mode),
    .exp_data_i(exp_data),
    .exp_err_i (exp_err),
    .errors_o  (errors)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // fibonacci lfsr with taps 32 22 2 1.
  function automatic logic lfsr_step();
    logic fb;
    fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
    lfsr_q = {lfsr_q[30:0], fb};
    return fb;
  endfunction

  task automatic random_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_step()};
    end
  endtask

  // one apb transfer with its setup phase and access phases until pready.
  task automatic apb_xfer(input logic we, input logic [31:0] a, input logic [31:0] d,
                          input logic [1:0] mode, input int err, output logic [31:0] rd);
    @(negedge clk);
    psel     = 1'b1;
    penable  = 1'b0;
    pwrite   = we;
    paddr    = a[APB_AW-1:0];
    pwdata   = we ? d : 32'h0;
    cmp_mode = mode;
    exp_data = d;
    exp_err  = err[0];
    @(negedge clk);
    penable = 1'b1;
    @(posedge clk);
    while (!pready) @(posedge clk);
    rd = prdata;
    @(negedge clk);
    psel     = 1'b0;
    penable  = 1'b0;
    cmp_mode = 2'd0;
  endtask

  task automatic poll_done();
    logic [31:0] rd;
    rd = '0;
    while (!rd[STATUS_DONE_BIT]) begin
      apb_xfer(1'b0, 32'(REG_STATUS), 32'h0, 2'd0, 0, rd);
    end
  endtask

  task automatic load_stim();
    int          fd;
    int          e;
    string       op;
    string       rest;
    logic [31:0] a;
    logic [31:0] d;
    fd = $fopen("conv_acc_stim.txt", "r");
    if (fd == 0) begin
      $display("could not open the stimulus file conv_acc_stim.txt");
      tb_errors++;
      return;
    end
    while ($fscanf(fd, "%s", op) == 1) begin
      if (op == "#") begin
        void'($fgets(rest, fd));
      end else if ($fscanf(fd, "%h %h %d", a, d, e) == 3) begin
        rec_op.push_back(op);
        rec_addr.push_back(a);
        rec_data.push_back(d);
        rec_err.push_back(e);
      end else begin
        $display("malformed record in the stimulus file after op %s", op);
        tb_errors++;
      end
    end
    $fclose(fd);
  endtask

  initial begin
    wait (limit > 0);
    repeat (limit) @(posedge clk);
    $display("watchdog expired after %0d cycles, the run did not finish", limit);
    $display("Checks failed");
    $finish;
  end

  initial begin
    logic [31:0] rd;
    logic [31:0] v;
    int          runs;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    paddr     = '0;
    pwdata    = '0;
    cmp_mode  = 2'd0;
    exp_data  = '0;
    exp_err   = 1'b0;
    tb_errors = 0;
    limit     = 0;
    lfsr_q    = 32'hf9549fdb;
    rst       = 1'b1;
    load_stim();
    runs = 1;
    foreach (rec_op[i]) begin
      if (rec_op[i] == "w" && rec_addr[i] == 32'(REG_CTRL)) runs++;
    end
    // the lfsr fill and readback add about ten cycles per word.
    limit = rec_op.size() * 40 + runs * 300 + BUF_DEPTH * 10;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // directed records.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    foreach (rec_op[i]) begin
      if (rec_op[i] == "w") begin
        apb_xfer(1'b1, rec_addr[i], rec_data[i], 2'd1, rec_err[i], rd);
      end else if (rec_op[i] == "r") begin
        apb_xfer(1'b0, rec_addr[i], rec_data[i], 2'd1, rec_err[i], rd);
      end else if (rec_op[i] == "m") begin
        apb_xfer(1'b0, rec_addr[i], 32'h0, 2'd2, 0, rd);
      end else if (rec_op[i] == "p") begin
        poll_done();
      end else begin
        $display("unknown op %s in the stimulus file", rec_op[i]);
        tb_errors++;
      end
    end

    // full-length run on lfsr samples and taps.
    for (int a = 0; a < BUF_DEPTH; a++) begin
      random_bits(16, v);
      apb_xfer(1'b1, 32'(IN_WIN_BASE) + 32'(a * 4), v, 2'd2, 0, rd);
    end
    apb_xfer(1'b1, 32'(REG_LEN), 32'd254, 2'd2, 0, rd);
    random_bits(16, v);
    apb_xfer(1'b1, 32'(REG_K0), v, 2'd2, 0, rd);
    random_bits(16, v);
    apb_xfer(1'b1, 32'(REG_K1), v, 2'd2, 0, rd);
    random_bits(16, v);
    apb_xfer(1'b1, 32'(REG_K2), v, 2'd2, 0, rd);
    apb_xfer(1'b1, 32'(REG_CTRL), 32'h1, 2'd1, 0, rd);
    poll_done();
    for (int a = 0; a < 254; a++) begin
      apb_xfer(1'b0, 32'(OUT_WIN_BASE) + 32'(a * 4), 32'h0, 2'd2, 0, rd);
    end
    apb_xfer(1'b0, 32'(REG_STATUS), 32'h2, 2'd1, 0, rd);
    apb_xfer(1'b0, 32'(REG_LEN), 32'h0, 2'd2, 0, rd);

    repeat (3) @(posedge clk);
    $display("errors: checker %0d, testbench %0d", errors, tb_errors);
    if (errors == 0 && tb_errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule
